/* verilog/uart_rx_defs.svh */
// Shared constants for the UART receiver with Wishbone register port.
// Include this wherever a width, depth, address or reset value is needed.

`ifndef UART_RX_DEFS_SVH
`define UART_RX_DEFS_SVH

//////////////////////////////////////////////////
// frame format
//////////////////////////////////////////////////

// data bits per frame
`define UART_DATA_W 8

//////////////////////////////////////////////////
// receive buffer
//////////////////////////////////////////////////

`define UART_FIFO_DEPTH 4 // words, keep a power of two

//////////////////////////////////////////////////
// wishbone register map, word addresses
//////////////////////////////////////////////////

`define UART_ADDR_DATA   2'd0 // rx word, read pops
`define UART_ADDR_STATUS 2'd1 // empty, full, overrun
`define UART_ADDR_CTRL   2'd2 // prescale and parity setup

//////////////////////////////////////////////////
// control register reset value
//////////////////////////////////////////////////

// oversampling ratio out of reset, 8, 16 or 32 are legal
`define UART_PRESCALE_RST 6'd16

`endif

/* verilog/uart_rx_pkg.sv */
// Types shared by the UART receiver blocks and the bound checker.
// Referenced by scoped name, never imported.

`default_nettype none

`include "uart_rx_defs.svh"

package uart_rx_pkg;

    //////////////////////////////////////////////////
    // received word, also the fifo payload
    //////////////////////////////////////////////////

    // bit 9 framing error, bit 8 parity error, bits 7..0 data
    typedef struct packed {
        logic                      framing_err; // stop bit sampled as 0
        logic                      parity_err;  // parity bit mismatch
        logic [`UART_DATA_W-1:0]   data;        // lsb received first
    } rx_word_t;

    //////////////////////////////////////////////////
    // frame state machine
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        st_idle,   // waiting for a falling line
        st_start,  // start bit, glitch check at its end
        st_data,   // shifting data bits
        st_parity, // optional parity bit
        st_stop    // stop bit, push or overrun
    } frame_state_t;

    //////////////////////////////////////////////////
    // register port
    //////////////////////////////////////////////////

    typedef logic [1:0] reg_addr_t; // word address

endpackage

`default_nettype wire

/* verilog/rx_bit_sampler.sv */
// Input side of the receiver. Synchronizes the serial line, counts
// oversampling edges per bit and majority-votes three mid-bit samples.
// The frame FSM enables it and clears the counter between frames.

`default_nettype none

module rx_bit_sampler (
    input  logic       CLK,
    input  logic       arst_n,
    input  logic       rx,
    input  logic [5:0] prescale,
    input  logic       sampler_en,
    input  logic       clear_counters,
    output logic       start_edge,
    output logic       bit_done,
    output logic       sampled_bit
);

    //////////////////////////////////////////////////
    // line synchronizer
    //////////////////////////////////////////////////

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1; // line idles high
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge = rx_prev & ~rx_sync; // falling synchronized line

    //////////////////////////////////////////////////
    // edge counter
    //////////////////////////////////////////////////

    logic [5:0] edge_cnt;
    logic [5:0] last_edge;
    logic [5:0] mid_edge;

    assign last_edge = prescale - 6'd1;
    assign mid_edge  = {1'b0, prescale[5:1]};

    // >= so a prescale change mid-frame cannot run the counter away
    assign bit_done = sampler_en & (edge_cnt >= last_edge);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            edge_cnt <= '0;
        end else if (clear_counters) begin
            edge_cnt <= '0;
        end else if (sampler_en) begin
            edge_cnt <= bit_done ? 6'd0 : edge_cnt + 6'd1; // wrap each bit
        end
    end

    //////////////////////////////////////////////////
    // mid-bit samples and vote
    //////////////////////////////////////////////////

    logic [2:0] samples;

    always_ff @(posedge CLK) begin
        if (sampler_en) begin
            if (edge_cnt == mid_edge - 6'd1) begin
                samples[0] <= rx_sync;
            end
            if (edge_cnt == mid_edge) begin
                samples[1] <= rx_sync;
            end
            if (edge_cnt == mid_edge + 6'd1) begin
                samples[2] <= rx_sync;
            end
        end
    end

    // two out of three
    assign sampled_bit = (samples[0] & samples[1]) |
                         (samples[0] & samples[2]) |
                         (samples[1] & samples[2]);

endmodule

`default_nettype wire

/* verilog/rx_frame_fsm.sv */
// Frame state machine of the receiver. Walks start, data, parity and stop,
// shifting data lsb first and folding parity on the way. Pushes the word
// into the FIFO on the stop bit, or flags overrun when the FIFO is full.

`default_nettype none

`include "uart_rx_defs.svh"

module rx_frame_fsm (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic                  start_edge,
    input  logic                  bit_done,
    input  logic                  sampled_bit,
    input  logic                  par_en,
    input  logic                  par_typ,
    input  logic                  full,
    output logic                  sampler_en,
    output logic                  clear_counters,
    output logic                  push,
    output uart_rx_pkg::rx_word_t wdata,
    output logic                  overrun_set
);

    localparam int CNT_W = $clog2(`UART_DATA_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`UART_DATA_W - 1);

    uart_rx_pkg::frame_state_t state;
    uart_rx_pkg::frame_state_t state_nxt;

    logic [CNT_W-1:0]        bit_cnt;
    logic [`UART_DATA_W-1:0] shift_q;  // deserialized data
    logic                    par_acc;  // xor of data bits so far
    logic                    par_err_q;

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            uart_rx_pkg::st_idle: begin
                if (start_edge) begin
                    state_nxt = uart_rx_pkg::st_start;
                end
            end
            uart_rx_pkg::st_start: begin
                if (bit_done) begin
                    // a 1 here means the low pulse was a glitch
                    state_nxt = sampled_bit ? uart_rx_pkg::st_idle : uart_rx_pkg::st_data;
                end
            end
            uart_rx_pkg::st_data: begin
                if (bit_done && bit_cnt == LAST_BIT) begin
                    state_nxt = par_en ? uart_rx_pkg::st_parity : uart_rx_pkg::st_stop;
                end
            end
            uart_rx_pkg::st_parity: begin
                if (bit_done) begin
                    state_nxt = uart_rx_pkg::st_stop;
                end
            end
            uart_rx_pkg::st_stop: begin
                if (bit_done) begin
                    // back-to-back frame can start on this very cycle
                    state_nxt = start_edge ? uart_rx_pkg::st_start : uart_rx_pkg::st_idle;
                end
            end
            default: state_nxt = uart_rx_pkg::st_idle;
        endcase
    end

    //////////////////////////////////////////////////
    // state and datapath registers
    //////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state     <= uart_rx_pkg::st_idle;
            bit_cnt   <= '0;
            par_acc   <= 1'b0;
            par_err_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == uart_rx_pkg::st_start) begin
                bit_cnt   <= '0; // fresh frame
                par_acc   <= 1'b0;
                par_err_q <= 1'b0;
            end else if (bit_done && state == uart_rx_pkg::st_data) begin
                bit_cnt <= bit_cnt + 1'b1;
                par_acc <= par_acc ^ sampled_bit;
            end else if (bit_done && state == uart_rx_pkg::st_parity) begin
                // odd parity expects the inverse of the data xor
                par_err_q <= sampled_bit ^ par_acc ^ par_typ;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (bit_done && state == uart_rx_pkg::st_data) begin
            shift_q <= {sampled_bit, shift_q[`UART_DATA_W-1:1]}; // lsb first
        end
    end

    //////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////

    assign sampler_en     = (state != uart_rx_pkg::st_idle);
    assign clear_counters = (state == uart_rx_pkg::st_idle);

    assign push        = (state == uart_rx_pkg::st_stop) & bit_done & ~full;
    assign overrun_set = (state == uart_rx_pkg::st_stop) & bit_done & full; // word lost

    always_comb begin
        wdata.data        = shift_q;
        wdata.parity_err  = par_err_q;
        wdata.framing_err = ~sampled_bit; // stop bit must be 1
    end

endmodule

`default_nettype wire

/* verilog/rx_fifo.sv */
// Synchronous FIFO for received words. The payload type is a parameter.
// Head entry falls through to rdata; push when full and pop when empty
// are both ignored.

`default_nettype none

module rx_fifo #(
    parameter type         payload_t = logic [7:0],
    parameter int unsigned depth     = 4 // power of two
) (
    input  logic     CLK,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t wdata,
    input  logic     pop,
    output payload_t rdata,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = $clog2(depth + 1);

    payload_t mem [depth];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(depth));
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge CLK) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    assign rdata = mem[rd_ptr]; // fall-through head

endmodule

`default_nettype wire

/* verilog/rx_wb_port.sv */
// Wishbone classic slave for the UART receiver. Serves DATA, STATUS and
// CTRL, acks one cycle after the request and pops the FIFO on DATA reads.
// Holds the control register and the sticky overrun flag.

`default_nettype none

`include "uart_rx_defs.svh"

module rx_wb_port (
    input  logic                   CLK,
    input  logic                   arst_n,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  uart_rx_pkg::reg_addr_t adr,
    input  logic [31:0]            dat_w,
    input  logic [3:0]             sel,
    output logic [31:0]            dat_r,
    output logic                   ack,
    input  uart_rx_pkg::rx_word_t  rdata,
    input  logic                   empty,
    input  logic                   full,
    input  logic                   overrun_set,
    output logic                   pop,
    output logic [5:0]             prescale,
    output logic                   par_en,
    output logic                   par_typ
);

    logic overrun;
    logic acc_rd; // acknowledged read
    logic acc_wr; // acknowledged write

    //////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= cyc & stb & ~ack; // single cycle, drops with stb high
        end
    end

    assign acc_rd = cyc & stb & ack & ~we;
    assign acc_wr = cyc & stb & ack & we;

    assign pop = acc_rd & (adr == `UART_ADDR_DATA) & ~empty;

    //////////////////////////////////////////////////
    // control and status registers
    //////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            prescale <= `UART_PRESCALE_RST;
            par_en   <= 1'b0;
            par_typ  <= 1'b0;
        end else if (acc_wr && adr == `UART_ADDR_CTRL) begin
            if (sel[0]) begin
                prescale <= dat_w[5:0];
            end
            if (sel[1]) begin
                par_en  <= dat_w[8];
                par_typ <= dat_w[9]; // 1 = odd
            end
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            overrun <= 1'b0;
        end else if (overrun_set) begin
            overrun <= 1'b1; // a new loss beats the clearing read
        end else if (acc_rd && adr == `UART_ADDR_STATUS) begin
            overrun <= 1'b0;
        end
    end

    // read mux
    always_comb begin
        dat_r = '0;
        case (adr)
            `UART_ADDR_DATA:   dat_r[9:0] = empty ? 10'd0 : rdata;
            `UART_ADDR_STATUS: dat_r[2:0] = {overrun, full, empty};
            `UART_ADDR_CTRL:   dat_r[9:0] = {par_typ, par_en, 2'b00, prescale};
            default:           dat_r = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/uart_rx_wb.sv */
// Top level of the UART receiver with a Wishbone classic slave port.
// Wires the bit sampler, frame FSM, receive FIFO and register port.

`default_nettype none

`include "uart_rx_defs.svh"

module uart_rx_wb (
    input  logic                   CLK,
    input  logic                   arst_n,
    input  logic                   rx,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  uart_rx_pkg::reg_addr_t adr,
    input  logic [31:0]            dat_w,
    input  logic [3:0]             sel,
    output logic [31:0]            dat_r,
    output logic                   ack
);

    logic                  start_edge;
    logic                  bit_done;
    logic                  sampled_bit;
    logic                  sampler_en;
    logic                  clear_counters;
    logic                  push;
    logic                  pop;
    logic                  empty;
    logic                  full;
    logic                  overrun_set;
    logic [5:0]            prescale;
    logic                  par_en;
    logic                  par_typ;
    uart_rx_pkg::rx_word_t wdata;
    uart_rx_pkg::rx_word_t rdata;

    rx_bit_sampler sampler_i (
        .CLK(CLK), .arst_n(arst_n), .rx(rx), .prescale(prescale),
        .sampler_en(sampler_en), .clear_counters(clear_counters),
        .start_edge(start_edge), .bit_done(bit_done), .sampled_bit(sampled_bit)
    );

    rx_frame_fsm fsm_i (
        .CLK(CLK), .arst_n(arst_n), .start_edge(start_edge), .bit_done(bit_done),
        .sampled_bit(sampled_bit), .par_en(par_en), .par_typ(par_typ), .full(full),
        .sampler_en(sampler_en), .clear_counters(clear_counters), .push(push),
        .wdata(wdata), .overrun_set(overrun_set)
    );

    rx_fifo #(
        .payload_t(uart_rx_pkg::rx_word_t),
        .depth    (`UART_FIFO_DEPTH)
    ) fifo_i (
        .CLK(CLK), .arst_n(arst_n), .push(push), .wdata(wdata), .pop(pop),
        .rdata(rdata), .empty(empty), .full(full)
    );

    rx_wb_port wb_i (
        .CLK(CLK), .arst_n(arst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack), .rdata(rdata),
        .empty(empty), .full(full), .overrun_set(overrun_set), .pop(pop),
        .prescale(prescale), .par_en(par_en), .par_typ(par_typ)
    );

endmodule

`default_nettype wire

/* tests/uart_rx_wb_checker.sv */
// Checker bound into the Wishbone register port of the UART receiver.
// Watches the classic handshake, the pop strobe and the FIFO flags.

`default_nettype none

module uart_rx_wb_checker (
    input logic clk,
    input logic arst_n,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic pop,
    input logic empty,
    input logic full
);

    //////////////////////////////////////////////////
    // classic handshake
    //////////////////////////////////////////////////

    ack_single: assert property (@(posedge clk) disable iff (!arst_n) ack |=> !ack)
        else $error("ack held high for more than one cycle");

    // request seen, ack on the next edge
    ack_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
        (cyc && stb && !ack) |=> ack)
        else $error("no ack one cycle after the request");

    ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        ack |-> $past(cyc && stb))
        else $error("ack without a request in the previous cycle");

    //////////////////////////////////////////////////
    // fifo side
    //////////////////////////////////////////////////

    // occupancy only drops through a pop
    full_until_pop: assert property (@(posedge clk) disable iff (!arst_n)
        (full && !pop) |=> full)
        else $error("FIFO left full without a pop");

    pop_frees_slot: assert property (@(posedge clk) disable iff (!arst_n) pop |=> !full)
        else $error("FIFO still full after a pop");

    // one push per cycle at most
    no_jump_to_full: assert property (@(posedge clk) disable iff (!arst_n) empty |=> !full)
        else $error("FIFO went from empty to full in one cycle");

endmodule

bind rx_wb_port uart_rx_wb_checker chk_i (
    .clk(CLK), .arst_n(arst_n), .cyc(cyc), .stb(stb), .ack(ack), .pop(pop),
    .empty(empty), .full(full)
);

`default_nettype wire

/* tests/uart_rx_tb.sv */
// Testbench for the UART receiver with Wishbone port. Frames come from
// tests/uart_rx_stimulus.txt; run from the project root. Each frame is sent
// serially, then STATUS and DATA are read back and compared.

`default_nettype none

`include "uart_rx_defs.svh"

module uart_rx_tb;

    typedef struct packed {
        logic [5:0] prescale;
        logic       par_en;
        logic       par_typ; // 1 = odd
        logic [7:0] data;
        logic       bad_par;
        logic       bad_stop;
        logic       glitch;
        logic       read_delay; // leave word in the FIFO
    } frame_t;

    logic                   clk;
    logic                   arst_n;
    logic                   rx;
    logic                   cyc;
    logic                   stb;
    logic                   we;
    uart_rx_pkg::reg_addr_t adr;
    logic [31:0]            dat_w;
    logic [3:0]             sel;
    logic [31:0]            dat_r;
    logic                   ack;

    frame_t      frames[$];
    logic [9:0]  exp_q[$]; // words the FIFO should hold
    logic        exp_ovr;
    int          err_cnt;
    int          cycle_cnt;
    int          cycle_limit;
    logic [31:0] lcg_state;

    uart_rx_wb dut_i (
        .CLK(clk), .arst_n(arst_n), .rx(rx), .cyc(cyc), .stb(stb), .we(we),
        .adr(adr), .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // watchdog
    initial begin
        cycle_cnt = 0;
        wait (cycle_limit != 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout, run still busy after %0d cycles", cycle_cnt);
        $display("errors: %0d", err_cnt);
        $display("** FAIL **");
        $finish;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic parity_bit(input frame_t f);
        return (^f.data) ^ f.par_typ ^ f.bad_par; // odd inverts the xor
    endfunction

    function automatic logic [9:0] expected_word(input frame_t f);
        // parity error only counts when parity is checked
        return {f.bad_stop, f.par_en & f.bad_par, f.data};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic wb_access(input logic we_v, input uart_rx_pkg::reg_addr_t adr_v,
                             input logic [31:0] wdata_v, input logic [3:0] sel_v,
                             output logic [31:0] rdata_v);
        int waited;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = we_v;
        adr   = adr_v;
        dat_w = wdata_v;
        sel   = sel_v;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack && waited < 8);
        assert (ack) else begin
            $display("no Wishbone ack for address %0d within %0d cycles", adr_v, waited);
            err_cnt++;
        end
        rdata_v = dat_r; // stable mid-cycle
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic send_level(input logic level, input int ncyc);
        rx = level;
        repeat (ncyc) @(negedge clk);
    endtask

    task automatic send_frame(input frame_t f, input int gap);
        int p;
        int i;
        p = int'(f.prescale);
        if (f.glitch) begin
            send_level(1'b0, p / 4); // well short of mid-bit
            send_level(1'b1, p + gap);
        end else begin
            send_level(1'b0, p);
            for (i = 0; i < `UART_DATA_W; i++) begin
                send_level(f.data[i], p); // lsb first
            end
            if (f.par_en) begin
                send_level(parity_bit(f), p);
            end
            send_level(~f.bad_stop, p);
            send_level(1'b1, gap);
        end
    endtask

    task automatic drain_and_check();
        logic [31:0] rd;
        logic [9:0]  exp_word;
        int          polls;
        polls = 0;
        // wait for the last word to land
        do begin
            wb_access(1'b0, `UART_ADDR_STATUS, 32'd0, 4'hf, rd);
            polls++;
        end while (exp_q.size() != 0 && rd[0] && polls < 16);
        assert (!(exp_q.size() != 0 && rd[0])) else begin
            $display("received word never reached the FIFO after %0d STATUS reads", polls);
            err_cnt++;
        end
        check_value("status", rd,
                    {29'd0, exp_ovr, exp_q.size() == `UART_FIFO_DEPTH, exp_q.size() == 0});
        exp_ovr = 1'b0; // cleared by that read
        while (exp_q.size() != 0) begin
            exp_word = exp_q.pop_front();
            wb_access(1'b0, `UART_ADDR_DATA, 32'd0, 4'hf, rd);
            check_value("dat_r data", rd, {22'd0, exp_word});
        end
        wb_access(1'b0, `UART_ADDR_STATUS, 32'd0, 4'hf, rd);
        check_value("status after drain", rd, 32'h1);
    endtask

    task automatic load_stimulus();
        int     fd;
        int     n;
        int     fld [8];
        string  line;
        frame_t f;
        fd = $fopen("tests/uart_rx_stimulus.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the stimulus file");
            err_cnt++;
        end
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%d %d %d %h %d %d %d %d", fld[0], fld[1], fld[2],
                            fld[3], fld[4], fld[5], fld[6], fld[7]);
                if (n == 8) begin // comment and blank lines skipped
                    f.prescale   = 6'(fld[0]);
                    f.par_en     = fld[1][0];
                    f.par_typ    = fld[2][0];
                    f.data       = 8'(fld[3]);
                    f.bad_par    = fld[4][0];
                    f.bad_stop   = fld[5][0];
                    f.glitch     = fld[6][0];
                    f.read_delay = fld[7][0];
                    frames.push_back(f);
                end
            end
            $fclose(fd);
        end
        assert (frames.size() != 0) else begin
            $display("stimulus file holds no frames");
            err_cnt++;
        end
        // 11 bits plus gap per frame, plus register traffic
        cycle_limit = 1000;
        foreach (frames[i]) begin
            cycle_limit += 13 * int'(frames[i].prescale) + 200;
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        frame_t      f;
        logic [31:0] rd;
        logic [31:0] rnd;
        int          gap;
        int          idx;
        arst_n    = 1'b0;
        rx        = 1'b1;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = `UART_ADDR_DATA;
        dat_w     = 32'd0;
        sel       = 4'h0;
        err_cnt   = 0;
        exp_ovr   = 1'b0;
        lcg_state = 32'h79ce7db6;
        load_stimulus();
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // reset values
        wb_access(1'b0, `UART_ADDR_STATUS, 32'd0, 4'hf, rd);
        check_value("status after reset", rd, 32'h1);
        wb_access(1'b0, `UART_ADDR_CTRL, 32'd0, 4'hf, rd);
        check_value("ctrl after reset", rd, 32'h10);
        wb_access(1'b0, `UART_ADDR_DATA, 32'd0, 4'hf, rd);
        check_value("dat_r on empty FIFO", rd, 32'h0);

        // byte 1 only, parity on and odd
        wb_access(1'b1, `UART_ADDR_CTRL, 32'h0000_0308, 4'b0010, rd);
        wb_access(1'b0, `UART_ADDR_CTRL, 32'd0, 4'hf, rd);
        check_value("ctrl after sel 0010", rd, 32'h0000_0310);
        wb_access(1'b1, `UART_ADDR_CTRL, 32'h0000_0008, 4'b0001, rd); // prescale only
        wb_access(1'b0, `UART_ADDR_CTRL, 32'd0, 4'hf, rd);
        check_value("ctrl after sel 0001", rd, 32'h0000_0308);

        for (idx = 0; idx < frames.size(); idx++) begin
            f = frames[idx];
            wb_access(1'b1, `UART_ADDR_CTRL,
                      {22'd0, f.par_typ, f.par_en, 2'b00, f.prescale}, 4'b0011, rd);
            rnd = next_random();
            gap = 4 + int'(rnd[23:16]) % int'(f.prescale);
            send_frame(f, gap);
            if (!f.glitch) begin
                if (exp_q.size() < `UART_FIFO_DEPTH) begin
                    exp_q.push_back(expected_word(f));
                end else begin
                    exp_ovr = 1'b1; // word dropped
                end
            end
            if (!f.read_delay) begin
                drain_and_check();
            end
        end

        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* uart_rx_wb.f */
+incdir+verilog
verilog/uart_rx_pkg.sv
verilog/rx_bit_sampler.sv
verilog/rx_frame_fsm.sv
verilog/rx_fifo.sv
verilog/rx_wb_port.sv
verilog/uart_rx_wb.sv
tests/uart_rx_wb_checker.sv
tests/uart_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the UART receiver testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module uart_rx_tb \
        -f uart_rx_wb.f -o uart_rx_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/uart_rx_sim +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* tests/uart_rx_stimulus.txt */
# one frame per line, fields separated by spaces
# prescale par_en par_typ data(hex) bad_par bad_stop glitch read_delay
16 0 0 a5 0 0 0 0
8 0 0 3c 0 0 0 0
32 0 0 81 0 0 0 0
8 0 0 ff 0 0 0 1
8 0 0 00 0 0 0 0
16 1 0 5a 0 0 0 0
16 1 1 5a 0 0 0 0
16 1 0 c3 1 0 0 0
16 1 1 07 1 0 0 0
16 0 0 e7 0 1 0 0
8 0 0 55 0 0 1 0
32 1 1 99 0 1 0 0
16 0 0 11 0 0 0 1
16 0 0 22 0 0 0 1
16 0 0 33 0 0 0 1
16 0 0 44 0 0 0 1
16 0 0 55 0 0 0 0
